// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -f list.f --top-module lsu_tb
	./obj_dir/Vlsu_tb > $(LOG) 2>&1 || echo "Test failures found" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failures found" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== list.f ====
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_data_ram.sv
source/lsu_load_format.sv
source/lsu_top.sv
test/lsu_chk.sv
test/lsu_tb.sv

// ==== source/lsu_data_ram.sv ====
// byte-masked data memory
`default_nettype none

module lsu_data_ram (
  input  logic              clk,
  input  lsu_pkg::ram_req_t ram_req_i,
  output lsu_pkg::xlen_t    rdata_o
);

  lsu_pkg::xlen_t mem [lsu_pkg::RAM_WORDS];
  lsu_pkg::xlen_t rdata_q;

  // one write enable per byte lane
  always_ff @(posedge clk) begin
    for (int b = 0; b < lsu_pkg::XLEN_BYTES; b++) begin
      if (ram_req_i.wr_mask[b]) begin
        mem[ram_req_i.word][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
      end
    end
  end

  // registered read, holds the last word when idle
  always_ff @(posedge clk) begin
    if (ram_req_i.rd_en) begin
      rdata_q <= mem[ram_req_i.word];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== source/lsu_decode.sv ====
// load/store request decode
`default_nettype none

module lsu_decode (
  input  lsu_pkg::lsu_req_t req_i,
  output lsu_pkg::ram_req_t ram_req_o,
  output lsu_pkg::load_op_t load_op_o
);

  lsu_pkg::ls_info_t   info;
  lsu_pkg::lane_t      lane;
  lsu_pkg::size_oh_t   size;
  lsu_pkg::byte_mask_t size_mask;
  logic                size_onehot;
  logic                aligned;
  logic                access;
  logic                both_dirs;
  logic                fault;

  assign info = req_i.info;
  assign lane = req_i.alu_res[2:0];
  assign size = {info.size_d, info.size_w, info.size_h, info.size_b};

  // exactly one size bit set
  assign size_onehot = (size != 4'b0000) && ((size & (size - 4'd1)) == 4'b0000);

  // natural alignment for the requested size
  always_comb begin
    case (size)
      lsu_pkg::SIZE_B: aligned = 1'b1;
      lsu_pkg::SIZE_H: aligned = (lane[0] == 1'b0);
      lsu_pkg::SIZE_W: aligned = (lane[1:0] == 2'b00);
      lsu_pkg::SIZE_D: aligned = (lane == 3'b000);
      default:         aligned = 1'b0;
    endcase
  end

  // unshifted byte enables per size
  always_comb begin
    case (size)
      lsu_pkg::SIZE_B: size_mask = 8'b0000_0001;
      lsu_pkg::SIZE_H: size_mask = 8'b0000_0011;
      lsu_pkg::SIZE_W: size_mask = 8'b0000_1111;
      lsu_pkg::SIZE_D: size_mask = 8'b1111_1111;
      default:         size_mask = 8'b0000_0000;
    endcase
  end

  assign access    = info.is_load | info.is_store;
  assign both_dirs = info.is_load & info.is_store;

  // plain alu requests never fault, whatever the size bits say
  assign fault = access & (~size_onehot | ~aligned | both_dirs);

  // ram side, blocked on a fault
  always_comb begin
    ram_req_o.rd_en   = info.is_load & ~fault;
    ram_req_o.word    = req_i.alu_res[10:3];
    ram_req_o.wdata   = req_i.store_data << {lane, 3'b000};
    ram_req_o.wr_mask = '0;
    if (info.is_store && !fault) begin
      ram_req_o.wr_mask = size_mask << lane;
    end
  end

  // what the output side needs one cycle later
  always_comb begin
    load_op_o.valid       = req_i.valid;
    load_op_o.rd_idx      = req_i.rd_idx;
    load_op_o.alu_res     = req_i.alu_res;
    load_op_o.is_load     = info.is_load;
    load_op_o.is_unsigned = info.is_unsigned;
    load_op_o.size        = size;
    load_op_o.lane        = lane;
    load_op_o.fault       = fault;
  end

endmodule

`default_nettype wire

// ==== source/lsu_load_format.sv ====
// load data alignment and write-back
`default_nettype none

module lsu_load_format (
  input  logic              clk,
  input  logic              reset_i,
  input  lsu_pkg::load_op_t load_op_i,
  input  lsu_pkg::xlen_t    rdata_i,
  output lsu_pkg::lsu_wb_t  wb_o
);

  lsu_pkg::load_op_t op_q;
  lsu_pkg::xlen_t    shifted;
  lsu_pkg::xlen_t    load_data;

  // sign or zero extension from the access size
  function automatic lsu_pkg::xlen_t extend(
    input lsu_pkg::xlen_t    raw,
    input lsu_pkg::size_oh_t size,
    input logic              is_unsigned
  );
    lsu_pkg::xlen_t res;
    case (size)
      lsu_pkg::SIZE_B: begin
        if (is_unsigned) begin
          res = {56'b0, raw[7:0]};
        end else begin
          res = {{56{raw[7]}}, raw[7:0]};
        end
      end
      lsu_pkg::SIZE_H: begin
        if (is_unsigned) begin
          res = {48'b0, raw[15:0]};
        end else begin
          res = {{48{raw[15]}}, raw[15:0]};
        end
      end
      lsu_pkg::SIZE_W: begin
        if (is_unsigned) begin
          res = {32'b0, raw[31:0]};
        end else begin
          res = {{32{raw[31]}}, raw[31:0]};
        end
      end
      default: res = raw;
    endcase
    return res;
  endfunction

  // control fields cleared on reset, payload just follows
  always_ff @(posedge clk) begin
    op_q <= load_op_i;
    if (reset_i) begin
      op_q.valid   <= 1'b0;
      op_q.is_load <= 1'b0;
      op_q.fault   <= 1'b0;
    end
  end

  // addressed bytes down to bit 0
  assign shifted   = rdata_i >> {op_q.lane, 3'b000};
  assign load_data = extend(shifted, op_q.size, op_q.is_unsigned);

  always_comb begin
    wb_o.wr_en  = op_q.valid;
    wb_o.rd_idx = op_q.rd_idx;
    wb_o.fault  = op_q.fault;
    if (op_q.fault) begin
      wb_o.data = '0;
    end else if (op_q.is_load) begin
      wb_o.data = load_data;
    end else begin
      wb_o.data = op_q.alu_res;
    end
  end

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
// load/store unit shared types
`default_nettype none

package lsu_pkg;

  localparam int XLEN        = 64;
  localparam int XLEN_BYTES  = XLEN / 8;
  localparam int RAM_WORDS   = 256;

  typedef logic [XLEN-1:0]               xlen_t;
  typedef logic [4:0]                    reg_idx_t;
  typedef logic [XLEN_BYTES-1:0]         byte_mask_t;
  typedef logic [2:0]                    lane_t;
  typedef logic [$clog2(RAM_WORDS)-1:0]  ram_addr_t;

  // one-hot access size, bit 0 is byte
  typedef logic [3:0] size_oh_t;

  localparam size_oh_t SIZE_B = 4'b0001;
  localparam size_oh_t SIZE_H = 4'b0010;
  localparam size_oh_t SIZE_W = 4'b0100;
  localparam size_oh_t SIZE_D = 4'b1000;

  // same bit order as the core's ls_info bus, is_load at bit 0
  typedef struct packed {
    logic size_d;
    logic size_w;
    logic size_h;
    logic size_b;
    logic is_unsigned;
    logic is_store;
    logic is_load;
  } ls_info_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd_idx;
    xlen_t    alu_res;
    ls_info_t info;
    xlen_t    store_data;
  } lsu_req_t;

  typedef struct packed {
    logic       rd_en;
    byte_mask_t wr_mask;
    ram_addr_t  word;
    xlen_t      wdata;
  } ram_req_t;

  // request in flight between decode and the write-back register
  typedef struct packed {
    logic     valid;
    reg_idx_t rd_idx;
    xlen_t    alu_res;
    logic     is_load;
    logic     is_unsigned;
    size_oh_t size;
    lane_t    lane;
    logic     fault;
  } load_op_t;

  typedef struct packed {
    logic     wr_en;
    reg_idx_t rd_idx;
    xlen_t    data;
    logic     fault;
  } lsu_wb_t;

endpackage

`default_nettype wire

// ==== source/lsu_top.sv ====
// load/store stage top
`default_nettype none

module lsu_top (
  input  logic              clk,
  input  logic              reset_i,
  input  lsu_pkg::lsu_req_t req_i,
  output lsu_pkg::lsu_wb_t  wb_o
);

  lsu_pkg::ram_req_t ram_req;
  lsu_pkg::load_op_t load_op;
  lsu_pkg::xlen_t    ram_rdata;

  // combinational decode of the incoming request
  lsu_decode u_decode (
    .req_i     (req_i),
    .ram_req_o (ram_req),
    .load_op_o (load_op)
  );

  lsu_data_ram u_ram (
    .clk       (clk),
    .ram_req_i (ram_req),
    .rdata_o   (ram_rdata)
  );

  // one cycle after the request
  lsu_load_format u_format (
    .clk       (clk),
    .reset_i   (reset_i),
    .load_op_i (load_op),
    .rdata_i   (ram_rdata),
    .wb_o      (wb_o)
  );

endmodule

`default_nettype wire

// ==== test/lsu_chk.sv ====
// load/store stage assertions
`default_nettype none

module lsu_chk (
  input logic              clk,
  input logic              reset_i,
  input lsu_pkg::lsu_req_t req_i,
  input lsu_pkg::ram_req_t ram_req_i,
  input logic              fault_i,
  input lsu_pkg::lsu_wb_t  wb_i
);

  // faulting access must not touch the ram
  assert property (@(posedge clk) disable iff (reset_i)
    fault_i |-> (ram_req_i.wr_mask == '0))
    else $error("ram write mask set during a decode fault");

  assert property (@(posedge clk) disable iff (reset_i)
    wb_i.fault |-> $past(fault_i))
    else $error("write-back fault without a faulting request one edge earlier");

  // write-back enable one clock behind the request
  assert property (@(posedge clk) disable iff (reset_i)
    wb_i.wr_en == ($past(req_i.valid) && !$past(reset_i)))
    else $error("write-back enable does not follow the previous request valid");

endmodule

`default_nettype wire

// ==== test/lsu_tb.sv ====
// load/store stage testbench
`default_nettype none

module lsu_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;

  // entry kinds
  localparam logic [1:0] K_ST  = 2'd0;
  localparam logic [1:0] K_LD  = 2'd1;
  localparam logic [1:0] K_ALU = 2'd2;

  // info bits in ls_info order
  localparam logic [6:0] I_LD = 7'b000_0001;
  localparam logic [6:0] I_ST = 7'b000_0010;
  localparam logic [6:0] I_U  = 7'b000_0100;
  localparam logic [6:0] I_B  = 7'b000_1000;
  localparam logic [6:0] I_H  = 7'b001_0000;
  localparam logic [6:0] I_W  = 7'b010_0000;
  localparam logic [6:0] I_D  = 7'b100_0000;

  // top bit set in every byte, half and word
  localparam logic [63:0] NEG_PATTERN = 64'hf0e1_d2c3_b4a5_9687;

  typedef struct packed {
    logic [1:0]  kind;
    logic [6:0]  info;
    logic [63:0] addr;
    logic [4:0]  rd;
    logic        data_sel;
    logic        exp_fault;
  } entry_t;

  logic              clk;
  logic              reset;
  lsu_pkg::lsu_req_t req;
  lsu_pkg::lsu_wb_t  wb;

  entry_t            tbl[$];
  lsu_pkg::lsu_wb_t  exp_q[$];
  logic [7:0]        model_mem [lsu_pkg::RAM_WORDS * 8];
  logic [31:0]       lfsr_state;
  int                errors;
  logic              table_ready;

  lsu_top u_lsu_top (
    .clk     (clk),
    .reset_i (reset),
    .req_i   (req),
    .wb_o    (wb)
  );

  bind lsu_top lsu_chk u_chk (
    .clk       (clk),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .ram_req_i (ram_req),
    .fault_i   (load_op.fault),
    .wb_i      (wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [63:0] random_word();
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      w = {w[62:0], lfsr_bit()};
    end
    return w;
  endfunction

  // byte model of the memory updated in request order
  function automatic lsu_pkg::lsu_wb_t predict(input lsu_pkg::lsu_req_t r);
    lsu_pkg::lsu_wb_t res;
    logic [63:0]      val;
    logic             ld;
    logic             st;
    logic             fault;
    int               nbytes;
    int               lane;
    int               base;
    ld     = r.info.is_load;
    st     = r.info.is_store;
    nbytes = r.info.size_d ? 8 : r.info.size_w ? 4 : r.info.size_h ? 2 : 1;
    lane   = int'(r.alu_res[2:0]);
    base   = int'(r.alu_res[10:3]) * 8;
    fault  = (ld || st) && (($countones({r.info.size_d, r.info.size_w, r.info.size_h,
                                         r.info.size_b}) != 1) ||
                            ((lane % nbytes) != 0) || (ld && st));
    if (st && !fault) begin
      for (int i = 0; i < nbytes; i++) begin
        model_mem[base + lane + i] = r.store_data[8*i +: 8];
      end
    end
    val = '0;
    if (ld && !fault) begin
      for (int i = 0; i < nbytes; i++) begin
        val[8*i +: 8] = model_mem[base + lane + i];
      end
      if (!r.info.is_unsigned && nbytes < 8 && val[8*nbytes-1]) begin
        for (int i = nbytes; i < 8; i++) begin
          val[8*i +: 8] = 8'hff;
        end
      end
    end
    res.wr_en  = r.valid;
    res.rd_idx = r.rd_idx;
    res.fault  = fault;
    if (fault) begin
      res.data = '0;
    end else if (ld) begin
      res.data = val;
    end else begin
      res.data = r.alu_res;
    end
    return res;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_entry(input logic [1:0] kind, input logic [6:0] info,
                           input logic [63:0] addr, input logic [4:0] rd,
                           input logic data_sel, input logic exp_fault);
    entry_t e;
    e.kind      = kind;
    e.info      = info;
    e.addr      = addr;
    e.rd        = rd;
    e.data_sel  = data_sel;
    e.exp_fault = exp_fault;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // alu pass-through ignores the size bits
    add_entry(K_ALU, 7'd0, 64'h0123_4567_89ab_cdef, 5'd1, 1'b0, 1'b0);
    add_entry(K_ALU, I_B | I_H | I_W | I_D, 64'hfedc_ba98_7654_3210, 5'd2, 1'b0, 1'b0);
    add_entry(K_ALU, I_U | I_W, 64'h8000_0000_0000_0001, 5'd31, 1'b0, 1'b0);
    // double store then load back to back
    add_entry(K_ST, I_ST | I_D, 64'h000, 5'd0, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_D, 64'h000, 5'd3, 1'b0, 1'b0);
    add_entry(K_ST, I_ST | I_D, 64'h008, 5'd0, 1'b1, 1'b0);
    add_entry(K_ST, I_ST | I_D, 64'h0a0, 5'd0, 1'b0, 1'b0);
    add_entry(K_ST, I_ST | I_D, 64'h3f8, 5'd0, 1'b0, 1'b0);
    add_entry(K_ST, I_ST | I_D, 64'h7f8, 5'd0, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_D, 64'h008, 5'd4, 1'b0, 1'b0);
    // bytes at every lane
    for (int l = 0; l < 8; l++) begin
      add_entry(K_ST, I_ST | I_B, 64'h0a0 + 64'(l), 5'd0, l[0], 1'b0);
    end
    add_entry(K_LD, I_LD | I_B, 64'h0a1, 5'd5, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_B | I_U, 64'h0a3, 5'd6, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_B, 64'h0a4, 5'd7, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_B | I_U, 64'h0a6, 5'd8, 1'b0, 1'b0);
    // halves
    add_entry(K_ST, I_ST | I_H, 64'h008, 5'd0, 1'b0, 1'b0);
    add_entry(K_ST, I_ST | I_H, 64'h00a, 5'd0, 1'b1, 1'b0);
    add_entry(K_ST, I_ST | I_H, 64'h00c, 5'd0, 1'b1, 1'b0);
    add_entry(K_ST, I_ST | I_H, 64'h00e, 5'd0, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_H, 64'h00a, 5'd9, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_H | I_U, 64'h00c, 5'd10, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_H, 64'h008, 5'd11, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_H | I_U, 64'h00e, 5'd12, 1'b0, 1'b0);
    // words
    add_entry(K_ST, I_ST | I_W, 64'h3f8, 5'd0, 1'b1, 1'b0);
    add_entry(K_ST, I_ST | I_W, 64'h3fc, 5'd0, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_W, 64'h3f8, 5'd13, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_W | I_U, 64'h3f8, 5'd14, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_W | I_U, 64'h3fc, 5'd15, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_W, 64'h3fc, 5'd16, 1'b0, 1'b0);
    // whole words after narrow stores
    add_entry(K_LD, I_LD | I_D, 64'h0a0, 5'd17, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_D, 64'h008, 5'd18, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_D, 64'h3f8, 5'd19, 1'b0, 1'b0);
    // faults
    add_entry(K_ST, I_ST | I_H, 64'h003, 5'd0, 1'b0, 1'b1);
    add_entry(K_ST, I_ST | I_W, 64'h002, 5'd0, 1'b0, 1'b1);
    add_entry(K_ST, I_ST | I_D, 64'h004, 5'd0, 1'b0, 1'b1);
    add_entry(K_LD, I_LD | I_D, 64'h00c, 5'd20, 1'b0, 1'b1);
    add_entry(K_LD, I_LD | I_W, 64'h0a6, 5'd21, 1'b0, 1'b1);
    add_entry(K_LD, I_LD | I_H, 64'h0a1, 5'd22, 1'b0, 1'b1);
    add_entry(K_ST, I_ST | I_B | I_H, 64'h000, 5'd0, 1'b0, 1'b1);
    add_entry(K_LD, I_LD, 64'h008, 5'd23, 1'b0, 1'b1);
    add_entry(K_ST, I_LD | I_ST | I_D, 64'h000, 5'd0, 1'b0, 1'b1);
    add_entry(K_LD, I_LD | I_W | I_D, 64'h3f8, 5'd24, 1'b0, 1'b1);
    // word 0 untouched by the faulting stores
    add_entry(K_LD, I_LD | I_D, 64'h000, 5'd25, 1'b0, 1'b0);
    add_entry(K_LD, I_LD | I_B, 64'h7ff, 5'd26, 1'b0, 1'b0);
    // high address bits alias onto word 1
    add_entry(K_LD, I_LD | I_D, 64'h808, 5'd27, 1'b0, 1'b0);
    add_entry(K_ALU, 7'd0, 64'h5555_aaaa_5555_aaaa, 5'd28, 1'b0, 1'b0);
  endtask

  task automatic run_table();
    entry_t            e;
    lsu_pkg::lsu_req_t nxt;
    lsu_pkg::lsu_wb_t  exp;
    logic              exp_fault;
    for (int i = 0; i <= tbl.size(); i++) begin
      @(posedge clk);
      if (i < tbl.size()) begin
        e         = tbl[i];
        nxt       = '0;
        exp_fault = 1'b0;
        case (e.kind)
          K_ST: begin
            nxt.info       = e.info;
            nxt.alu_res    = e.addr;
            nxt.rd_idx     = e.rd;
            nxt.store_data = e.data_sel ? NEG_PATTERN : random_word();
            exp_fault      = e.exp_fault;
          end
          K_LD, K_ALU: begin
            nxt.valid   = 1'b1;
            nxt.info    = e.info;
            nxt.alu_res = e.addr;
            nxt.rd_idx  = e.rd;
            exp_fault   = e.exp_fault;
          end
          default: begin
            errors++;
            $display("unknown table entry %0d with kind %0d, sending an idle request",
                     i, e.kind);
          end
        endcase
        exp       = predict(nxt);
        exp.fault = exp_fault;
        exp_q.push_back(exp);
        req <= nxt;
      end else begin
        req <= '0;
      end
      @(negedge clk);
      if (i > 0) begin
        exp = exp_q.pop_front();
        check("wb_o.wr_en", 64'(wb.wr_en), 64'(exp.wr_en));
        check("wb_o.rd_idx", 64'(wb.rd_idx), 64'(exp.rd_idx));
        check("wb_o.data", wb.data, exp.data);
        check("wb_o.fault", 64'(wb.fault), 64'(exp.fault));
      end
    end
  endtask

  initial begin
    lsu_pkg::lsu_req_t busy_req;
    errors      = 0;
    table_ready = 1'b0;
    lfsr_state  = 32'h428b_2474;
    // valid misaligned load held through reset
    busy_req         = '0;
    busy_req.valid   = 1'b1;
    busy_req.info    = I_LD | I_H;
    busy_req.alu_res = 64'h1;
    busy_req.rd_idx  = 5'd30;
    reset <= 1'b1;
    req   <= busy_req;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    req   <= '0;
    @(negedge clk);
    check("wb_o.wr_en", 64'(wb.wr_en), 64'd0);
    check("wb_o.fault", 64'(wb.fault), 64'd0);
    run_table();
    $display("%0d errors over %0d table entries", errors, tbl.size());
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready === 1'b1);
    #((tbl.size() + 20) * CLK_PERIOD);
    $display("timeout, the table did not finish in the expected time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
